// File: Makefile
VERILATOR ?= verilator
TOP       ?= lrelu_engine_tb
FLAGS     ?= --binary --timing --assert -Wno-fatal
BUILD     ?= obj_dir
FILELIST  ?= lrelu_engine.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FLAGS BUILD FILELIST"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: hw/lrelu_cfg_pkg.sv
package lrelu_cfg_pkg;

  localparam int COEF_DEPTH = 4; // entries in each of A and B

  typedef logic [$clog2(COEF_DEPTH)-1:0] coef_addr_t;

  localparam coef_addr_t COEF_LAST = coef_addr_t'(COEF_DEPTH - 1);

  // order of words on the config stream
  typedef enum logic [1:0] {
    CFG_D,
    CFG_A,
    CFG_B
  } cfg_state_t;

  // one coefficient write, strobes are single cycle pulses
  typedef struct packed {
    logic                 wr_d;
    logic                 wr_a;
    logic                 wr_b;
    coef_addr_t           addr;
    lrelu_num_pkg::coef_t data;
  } coef_wr_t;

  // coefficients seen by the current item
  typedef struct packed {
    lrelu_num_pkg::coef_t a;
    lrelu_num_pkg::coef_t b;
    lrelu_num_pkg::coef_t d;
  } coef_set_t;

endpackage

// File: hw/lrelu_coeff_store.sv
`timescale 1ns/1ps

module lrelu_coeff_store (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     cfg_restart,
  input  lrelu_cfg_pkg::coef_wr_t  coef_wr,
  input  logic                     in_valid,
  output lrelu_cfg_pkg::coef_set_t coef
);

  import lrelu_num_pkg::*;
  import lrelu_cfg_pkg::*;

  coef_t      a_mem [COEF_DEPTH];
  coef_t      b_mem [COEF_DEPTH];
  coef_t      d_reg;
  coef_addr_t rd_ptr;

  always_ff @(posedge clk) begin
    if (clken) begin
      if (coef_wr.wr_a) a_mem[coef_wr.addr] <= coef_wr.data;
      if (coef_wr.wr_b) b_mem[coef_wr.addr] <= coef_wr.data;
      if (coef_wr.wr_d) d_reg <= coef_wr.data;
    end
  end

  // one entry per accepted item, cycles through the memories
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
    end else if (clken) begin
      if (cfg_restart) begin
        rd_ptr <= '0;
      end else if (in_valid) begin
        if (rd_ptr == COEF_LAST) rd_ptr <= '0;
        else                     rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // read is combinational so the item sees the entry in its own cycle
  assign coef = '{a: a_mem[rd_ptr], b: b_mem[rd_ptr], d: d_reg};

  // the decoder selects a single target per config word
  one_write_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({coef_wr.wr_d, coef_wr.wr_a, coef_wr.wr_b}));

endmodule

// File: hw/lrelu_config_decode.sv
`timescale 1ns/1ps

module lrelu_config_decode (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    clken,
  input  logic                    cfg_valid,
  input  logic                    cfg_restart,
  input  lrelu_num_pkg::coef_t    cfg_data,
  output lrelu_cfg_pkg::coef_wr_t coef_wr
);

  import lrelu_num_pkg::*;
  import lrelu_cfg_pkg::*;

  cfg_state_t state;
  coef_addr_t addr;
  logic       wr_d;
  logic       wr_a;
  logic       wr_b;
  coef_addr_t wr_addr;
  coef_t      wr_data;

  // D, then A[0..DEPTH-1], then B[0..DEPTH-1], then back to D
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CFG_D;
      addr  <= '0;
      wr_d  <= 1'b0;
      wr_a  <= 1'b0;
      wr_b  <= 1'b0;
    end else if (clken) begin
      wr_d <= 1'b0; // strobes drop after one cycle
      wr_a <= 1'b0;
      wr_b <= 1'b0;
      if (cfg_restart) begin
        state <= CFG_D;
        addr  <= '0;
      end else if (cfg_valid) begin
        unique case (state)
          CFG_D: begin
            wr_d  <= 1'b1;
            addr  <= '0;
            state <= CFG_A;
          end
          CFG_A: begin
            wr_a <= 1'b1;
            if (addr == COEF_LAST) begin
              addr  <= '0;
              state <= CFG_B;
            end else begin
              addr <= addr + 1'b1;
            end
          end
          CFG_B: begin
            wr_b <= 1'b1;
            if (addr == COEF_LAST) begin
              addr  <= '0;
              state <= CFG_D;
            end else begin
              addr <= addr + 1'b1;
            end
          end
          default: state <= CFG_D;
        endcase
      end
    end
  end

  // address and word of the pending write
  always_ff @(posedge clk) begin
    if (clken && cfg_valid) begin
      wr_addr <= addr;
      wr_data <= cfg_data;
    end
  end

  assign coef_wr = '{wr_d: wr_d, wr_a: wr_a, wr_b: wr_b, addr: wr_addr, data: wr_data};

  // D is always taken at entry 0, also after a restart
  d_at_entry_zero: assert property (@(posedge clk) disable iff (rst)
    (state == CFG_D) |-> (addr == '0));

endmodule

// File: hw/lrelu_engine.sv
`timescale 1ns/1ps

module lrelu_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     cfg_valid,
  input  logic                     cfg_restart,
  input  lrelu_num_pkg::coef_t     cfg_data,
  input  logic                     in_valid,
  input  lrelu_num_pkg::lane_vec_t in_item,
  output logic                     out_valid,
  output lrelu_num_pkg::out_vec_t  out_data
);

  import lrelu_num_pkg::*;
  import lrelu_cfg_pkg::*;

  coef_wr_t  coef_wr;
  coef_set_t coef;
  logic      stage_valid;
  lane_vec_t stage_item; // y*c + d, before clamping

  lrelu_config_decode lrelu_config_decode_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .cfg_valid   (cfg_valid),
    .cfg_restart (cfg_restart),
    .cfg_data    (cfg_data),
    .coef_wr     (coef_wr)
  );

  lrelu_coeff_store lrelu_coeff_store_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .cfg_restart (cfg_restart),
    .coef_wr     (coef_wr),
    .in_valid    (in_valid),
    .coef        (coef)
  );

  lrelu_execute lrelu_execute_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .in_valid    (in_valid),
    .in_item     (in_item),
    .coef        (coef),
    .stage_valid (stage_valid),
    .stage_item  (stage_item)
  );

  lrelu_result lrelu_result_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .stage_valid (stage_valid),
    .stage_item  (stage_item),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

endmodule

// File: hw/lrelu_execute.sv
`timescale 1ns/1ps

module lrelu_execute (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     in_valid,
  input  lrelu_num_pkg::lane_vec_t in_item,
  input  lrelu_cfg_pkg::coef_set_t coef,
  output logic                     stage_valid,
  output lrelu_num_pkg::lane_vec_t stage_item
);

  import lrelu_num_pkg::*;

  logic      s1_valid;
  lane_vec_t s1_item; // y per lane
  coef_t     s1_d;    // d travels with the item

  // (x*k + bias) >>> FRAC_BITS, k and bias in Q8.8
  function automatic acc_t scale_add(input acc_t x, input coef_t k, input coef_t bias);
    prod_t p;
    p = prod_t'(x) * prod_t'(k) + prod_t'(bias);
    return acc_t'(p >>> FRAC_BITS);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid    <= 1'b0;
      stage_valid <= 1'b0;
    end else if (clken) begin
      s1_valid    <= in_valid;
      stage_valid <= s1_valid;
    end
  end

  // stage 1: y = x*a + b
  always_ff @(posedge clk) begin
    if (clken) begin
      s1_item.lrelu <= in_item.lrelu;
      s1_d          <= coef.d;
      for (int i = 0; i < LANES; i++) begin
        s1_item.data[i] <= scale_add(in_item.data[i], coef.a, coef.b);
      end
    end
  end

  // stage 2: z = y*c + d, c leaks only for flagged negative y
  always_ff @(posedge clk) begin
    if (clken) begin
      stage_item.lrelu <= s1_item.lrelu;
      for (int i = 0; i < LANES; i++) begin
        stage_item.data[i] <= scale_add(s1_item.data[i],
          (s1_item.lrelu && s1_item.data[i][31]) ? ALPHA : ONE, s1_d);
      end
    end
  end

  // two enabled edges from input to stage output
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    (clken && in_valid) |=> clken [->1] ##1 stage_valid);

endmodule

// File: hw/lrelu_num_pkg.sv
package lrelu_num_pkg;

  localparam int LANES     = 4;
  localparam int FRAC_BITS = 8; // Q8.8 coefficients

  typedef logic signed [31:0] acc_t;  // accumulator word and intermediates
  typedef logic signed [15:0] coef_t; // Q8.8 coefficient
  typedef logic signed [7:0]  out_t;
  typedef logic signed [47:0] prod_t; // full width of acc_t times coef_t

  localparam coef_t ALPHA = 16'sd26;  // leak slope, about 0.1
  localparam coef_t ONE   = 16'sd256;

  // output clamp range
  localparam out_t OUT_MAX = 8'sd127;
  localparam out_t OUT_MIN = -8'sd128;

  // one item between stages, flag selects the leaky slope
  typedef struct packed {
    logic                   lrelu;
    acc_t [LANES-1:0]       data;
  } lane_vec_t;

  typedef struct packed {
    out_t [LANES-1:0] data;
  } out_vec_t;

endpackage

// File: hw/lrelu_result.sv
`timescale 1ns/1ps

module lrelu_result (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clken,
  input  logic                     stage_valid,
  input  lrelu_num_pkg::lane_vec_t stage_item,
  output logic                     out_valid,
  output lrelu_num_pkg::out_vec_t  out_data
);

  import lrelu_num_pkg::*;

  // clamp to the signed 8 bit range
  function automatic out_t sat8(input acc_t x);
    if (x > OUT_MAX) return OUT_MAX;
    if (x < OUT_MIN) return OUT_MIN;
    return out_t'(x);
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (clken) begin
      out_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (clken) begin
      for (int i = 0; i < LANES; i++) begin
        out_data.data[i] <= sat8(stage_item.data[i]);
      end
    end
  end

endmodule

// File: lrelu_engine.f
hw/lrelu_num_pkg.sv
hw/lrelu_cfg_pkg.sv
hw/lrelu_config_decode.sv
hw/lrelu_coeff_store.sv
hw/lrelu_execute.sv
hw/lrelu_result.sv
hw/lrelu_engine.sv
sim/lrelu_engine_tb.sv

// File: sim/lrelu_engine_tb.sv
`timescale 1ns/1ps

module lrelu_engine_tb;

  import lrelu_num_pkg::*;

  localparam logic [1:0] K_CFG     = 2'd0;
  localparam logic [1:0] K_RESTART = 2'd1;
  localparam logic [1:0] K_DATA    = 2'd2;
  localparam logic [1:0] K_IDLE    = 2'd3;

  // one line of the vector file
  typedef struct packed {
    logic [1:0]  kind;
    logic [31:0] arg;      // config word or idle length
    lane_vec_t   item;
    out_vec_t    want_out;
  } vec_rec_t;

  logic      clk = 1'b0;
  logic      rst;
  logic      clken;
  logic      cfg_valid;
  logic      cfg_restart;
  coef_t     cfg_data;
  logic      in_valid;
  lane_vec_t in_item;
  logic      out_valid;
  out_vec_t  out_data;

  vec_rec_t    vecs [$];
  out_vec_t    want_q [$];
  int unsigned due_q [$];  // enabled edge after which each output is due
  int unsigned en_edges = 0;
  logic        last_enabled = 1'b0;
  logic        want_valid;
  logic        loaded = 1'b0;

  lrelu_engine lrelu_engine_i (
    .clk         (clk),
    .rst         (rst),
    .clken       (clken),
    .cfg_valid   (cfg_valid),
    .cfg_restart (cfg_restart),
    .cfg_data    (cfg_data),
    .in_valid    (in_valid),
    .in_item     (in_item),
    .out_valid   (out_valid),
    .out_data    (out_data)
  );

  always #50 clk = ~clk;

  task automatic stop_with_failure();
    $display("Checks failed");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_valid(input logic got, input logic want);
    if (got !== want) begin
      $display("** Error out_valid: got %h, expected %h", got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_out_data(input out_vec_t got, input out_vec_t want);
    if (got !== want) begin
      $display("** Error out_data: got %h, expected %h", got, want);
      stop_with_failure();
    end
  endtask

  task automatic load_vectors();
    int          fd;
    logic        ok;
    string       line;
    vec_rec_t    rec;
    logic [31:0] arg;
    logic [31:0] flag;
    logic [31:0] x [LANES];
    logic [7:0]  e [LANES];
    fd = $fopen("sim/lrelu_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file sim/lrelu_vectors.txt");
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue; // blank or comment
      rec = '0;
      arg = '0;
      case (line.getc(0))
        "C": begin
          rec.kind = K_CFG;
          ok = ($sscanf(line, "C %h", arg) == 1);
        end
        "I": begin
          rec.kind = K_IDLE;
          ok = ($sscanf(line, "I %d", arg) == 1) && (arg != 0);
        end
        "R": begin
          rec.kind = K_RESTART;
          ok = 1'b1;
        end
        "D": begin
          rec.kind = K_DATA;
          ok = ($sscanf(line, "D %h %h %h %h %h %h %h %h %h", flag,
                        x[0], x[1], x[2], x[3], e[0], e[1], e[2], e[3]) == 9);
        end
        default: ok = 1'b0;
      endcase
      if (!ok) begin
        $display("malformed line in the vector file: %s", line);
        stop_with_failure();
      end
      rec.arg = arg;
      rec.item.lrelu = flag[0];
      for (int i = 0; i < LANES; i++) begin
        rec.item.data[i]     = x[i];
        rec.want_out.data[i] = e[i];
      end
      vecs.push_back(rec);
    end
    $fclose(fd);
  endtask

  // clken low cycles between vectors with the strobes dropped
  task automatic drive_gap();
    int unsigned gap;
    gap = $urandom_range(3, 0);
    repeat (gap) begin
      @(posedge clk);
      clken       <= 1'b0;
      cfg_valid   <= 1'b0;
      cfg_restart <= 1'b0;
      in_valid    <= 1'b0;
    end
  endtask

  task automatic apply_vector(input vec_rec_t rec);
    @(posedge clk);
    clken       <= 1'b1;
    cfg_valid   <= (rec.kind == K_CFG);
    cfg_restart <= (rec.kind == K_RESTART);
    in_valid    <= (rec.kind == K_DATA);
    cfg_data    <= rec.arg[15:0];
    in_item     <= rec.item;
    if (rec.kind == K_DATA) want_q.push_back(rec.want_out);
    if (rec.kind == K_IDLE) repeat (rec.arg - 1) @(posedge clk);
  endtask

  // outputs are checked half a cycle after each enabled edge
  always @(negedge clk) begin
    if (rst) begin
      last_enabled = 1'b0;
    end else begin
      if (last_enabled) begin
        want_valid = (due_q.size() != 0) && (due_q[0] == en_edges);
        check_valid(out_valid, want_valid);
        if (want_valid) begin
          check_out_data(out_data, want_q.pop_front());
          void'(due_q.pop_front());
        end
      end
      if (clken) begin
        en_edges++;
        if (in_valid) due_q.push_back(en_edges + 2); // 3 enabled edges
      end
      last_enabled = clken;
    end
  end

  initial begin
    wait (loaded);
    repeat (vecs.size() * 20) @(posedge clk);
    $display("timeout, the run did not finish within %0d cycles", vecs.size() * 20);
    stop_with_failure();
  end

  initial begin
    rst         = 1'b1;
    clken       = 1'b1;
    cfg_valid   = 1'b0;
    cfg_restart = 1'b0;
    cfg_data    = '0;
    in_valid    = 1'b0;
    in_item     = '0;
    void'($urandom(32'h58a3));
    load_vectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    foreach (vecs[i]) begin
      drive_gap();
      apply_vector(vecs[i]);
    end
    @(posedge clk);
    clken       <= 1'b1;
    cfg_valid   <= 1'b0;
    cfg_restart <= 1'b0;
    in_valid    <= 1'b0;
    while (want_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk); // watch for stray outputs
    $display("All checks passed");
    $finish;
  end

endmodule

// File: sim/lrelu_vectors.txt
# C <config word hex> | R restart | I <idle cycles, decimal>
# D <flag> <x0 x1 x2 x3, 32 bit hex> <expected out0 out1 out2 out3, 8 bit hex>
C 0000
C 0100
C 0100
C 0100
C 0100
C 0000
C 0000
C 0000
C 0000
I 2
D 0 00000005 fffffff9 0000007f ffffff80 05 f9 7f 80
D 0 000003e8 fffffc18 00000080 ffffff7f 7f 80 7f 80
D 1 ffffff9c 00000032 fffffff6 00000000 f5 32 fe 00
D 0 00000000 00000001 00000002 00000003 00 01 02 03
C 0200
C 0100
C 0200
C 0080
C ff00
C 0000
C 0100
C fe00
C 0a00
I 2
D 0 0000000a ffffffec 0000007c 0000007e 0c ee 7e 7f
D 1 00000003 fffffffb ffffffff 00000000 09 01 01 03
D 0 0000000a 00000000 fffffff9 0000012c 05 00 fc 7f
D 1 00000014 00000005 ffffff9c 000000c8 00 07 70 ee
D 1 ffffffce ffffffff 00000001 fffffc18 fc 01 03 9c
I 4
C 0700
C 0400
R
C 0100
I 2
D 1 0000000a fffffff8 00000002 ffffff9c 29 fd 09 d8
D 0 fffffffb 0000003c 00000000 ffffffba f8 7a 02 80
